// ==== rtl/kiwi_params.svh ====
`ifndef KIWI_PARAMS_SVH
`define KIWI_PARAMS_SVH

// Shared RAM address width, 8 KB
`define KIWI_RAM_AW 13

// ROM bus width, 128 KB of program space
`define KIWI_ROM_AW 17

// First 8 KB ROM page reached through the bank window
`define KIWI_BANK_BASE 4'd4

// Read value of open bus
`define KIWI_UNMAPPED 8'hff

// End of ROM space in the CPU map
`define KIWI_ROM_TOP 16'hc000

// Page of the bank/control latch
`define KIWI_BANK_PAGE 8'hf6

`endif

// ==== rtl/kiwi_pkg.sv ====
package kiwi_pkg;

    // One CPU bus access as issued by the master
    typedef struct packed {
        logic [15:0] addr;
        // Write data, ignored on reads
        logic [7:0]  data;
        // High for writes
        logic        we;
    } cpu_req_t;

    // Completed access
    typedef struct packed {
        // Read byte, zero for writes
        logic [7:0] data;
    } cpu_rsp_t;

    // Decoded bus target
    typedef enum logic [2:0] {
        DEV_ROM,
        DEV_VRAM,
        DEV_VCTRL,
        DEV_PAL,
        DEV_RAM,
        // Bank/sound reset latch at F6xx
        DEV_BANK,
        // Open bus
        DEV_NONE
    } dev_sel_t;

endpackage

// ==== rtl/kiwi_addr_decode.sv ====
`timescale 1ns/1ns
`include "kiwi_params.svh"

module kiwi_addr_decode (
    input  logic [15:0]             addr,
    input  logic [2:0]              bank,
    output kiwi_pkg::dev_sel_t      sel,
    output logic [`KIWI_ROM_AW-1:0] rom_addr
);

    // Page number on the ROM bus for the 8000-BFFF window
    logic [3:0] page;

    assign page = `KIWI_BANK_BASE + {1'b0, bank};

    // Region table, first match wins
    always_comb begin
        if (addr < `KIWI_ROM_TOP) begin
            sel = kiwi_pkg::DEV_ROM;
        end else if (addr[15:13] == 3'b110) begin
            // C000-DFFF
            sel = kiwi_pkg::DEV_VRAM;
        end else if (addr[15:12] == 4'he) begin
            // E000-EFFF, also seen by the sound CPU
            sel = kiwi_pkg::DEV_RAM;
        end else if (addr[15:10] == 6'b1111_00) begin
            // F000-F3FF, sprite RAM and video registers
            sel = kiwi_pkg::DEV_VCTRL;
        end else if (addr[15:8] == `KIWI_BANK_PAGE) begin
            // Latch only takes writes
            // the controller qualifies this with we
            sel = kiwi_pkg::DEV_BANK;
        end else if (addr[15:10] == 6'b1111_10) begin
            // F800-FBFF
            sel = kiwi_pkg::DEV_PAL;
        end else begin
            // F400-F5FF, F700-F7FF, FC00-FFFF
            sel = kiwi_pkg::DEV_NONE;
        end
    end

    // Lower 32 KB is fixed
    // upper window picks an 8 KB page
    always_comb begin
        if (!addr[15]) begin
            rom_addr = {1'b0, addr};
        end else begin
            rom_addr = {page, addr[12:0]};
        end
    end

endmodule

// ==== rtl/kiwi_bus_ctrl.sv ====
`timescale 1ns/1ns
`include "kiwi_params.svh"

module kiwi_bus_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  kiwi_pkg::cpu_req_t      req,
    input  logic                    req_valid,
    output logic                    req_ready,
    output kiwi_pkg::cpu_rsp_t      rsp,
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    input  kiwi_pkg::dev_sel_t      sel,
    input  logic [`KIWI_ROM_AW-1:0] rom_addr_in,
    output logic                    rom_cs,
    output logic                    vram_cs,
    output logic                    vctrl_cs,
    output logic                    pal_cs,
    output logic                    ram_we,
    output logic                    bank_we,
    output logic [`KIWI_ROM_AW-1:0] rom_addr,
    input  logic                    rom_ok,
    input  logic [7:0]              rom_data,
    input  logic [7:0]              ram_dout,
    input  logic [7:0]              vram_dout,
    input  logic [7:0]              pal_dout,
    output kiwi_pkg::cpu_req_t      cur
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_SELECT,
        S_WAIT_ROM,
        S_CAPTURE,
        S_RESPOND
    } state_t;

    state_t     state;
    // Read qualifier for the RAM, no port of its own
    logic       ram_cs;
    logic [7:0] rd_mux;

    // One access at a time, like the Z80 bus
    assign req_ready = (state == S_IDLE);

    // Read data priority as on the PCB
    always_comb begin
        if (cur.we) begin
            rd_mux = 8'h00;
        end else if (rom_cs) begin
            rd_mux = rom_data;
        end else if (ram_cs) begin
            rd_mux = ram_dout;
        end else if (vram_cs || vctrl_cs) begin
            // Video control reads come back on the VRAM bus
            rd_mux = vram_dout;
        end else if (pal_cs) begin
            rd_mux = pal_dout;
        end else begin
            rd_mux = `KIWI_UNMAPPED;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state     <= S_IDLE;
            rsp_valid <= 1'b0;
            rom_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            vctrl_cs  <= 1'b0;
            pal_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            ram_we    <= 1'b0;
            bank_we   <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req_valid) begin
                        state <= S_SELECT;
                    end
                end
                S_SELECT: begin
                    // Decode of the latched request is settled here
                    rom_cs   <= (sel == kiwi_pkg::DEV_ROM);
                    vram_cs  <= (sel == kiwi_pkg::DEV_VRAM);
                    vctrl_cs <= (sel == kiwi_pkg::DEV_VCTRL);
                    pal_cs   <= (sel == kiwi_pkg::DEV_PAL);
                    ram_cs   <= (sel == kiwi_pkg::DEV_RAM);
                    // Write strobes last a single cycle
                    ram_we   <= (sel == kiwi_pkg::DEV_RAM) && cur.we;
                    bank_we  <= (sel == kiwi_pkg::DEV_BANK) && cur.we;
                    state    <= S_WAIT_ROM;
                end
                S_WAIT_ROM: begin
                    ram_we  <= 1'b0;
                    bank_we <= 1'b0;
                    // Other targets pass straight through
                    if (!rom_cs || rom_ok) begin
                        state <= S_CAPTURE;
                    end
                end
                S_CAPTURE: begin
                    rsp_valid <= 1'b1;
                    rom_cs    <= 1'b0;
                    vram_cs   <= 1'b0;
                    vctrl_cs  <= 1'b0;
                    pal_cs    <= 1'b0;
                    ram_cs    <= 1'b0;
                    state     <= S_RESPOND;
                end
                S_RESPOND: begin
                    // Hold rsp until the master takes it
                    if (rsp_ready) begin
                        rsp_valid <= 1'b0;
                        state     <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Request, ROM address and read byte
    always_ff @(posedge clk) begin
        if (state == S_IDLE && req_valid) begin
            cur <= req;
        end
        if (state == S_SELECT) begin
            rom_addr <= rom_addr_in;
        end
        if (state == S_CAPTURE) begin
            rsp.data <= rd_mux;
        end
    end

endmodule

// ==== rtl/kiwi_sysctl.sv ====
`timescale 1ns/1ns

module kiwi_sysctl (
    input  logic       clk,
    input  logic       rst,
    input  logic       bank_we,
    input  logic [7:0] wdata,
    input  logic       lvbl,
    input  logic       irq_ack,
    output logic [2:0] bank,
    output logic       snd_rstn,
    output logic       irq
);

    // Previous lvbl for edge detect
    logic lvbl_l;

    // Control latch at F6xx
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            bank     <= 3'd0;
            // Sound CPU held in reset until the game releases it
            snd_rstn <= 1'b0;
        end else if (bank_we) begin
            bank     <= wdata[2:0];
            snd_rstn <= wdata[4];
        end
    end

    // Interrupt at start of vertical blank
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            lvbl_l <= 1'b0;
            irq    <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
            if (lvbl_l && !lvbl) begin
                // New blank wins over a late acknowledge
                irq <= 1'b1;
            end else if (irq_ack) begin
                irq <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/kiwi_shared_ram.sv ====
`timescale 1ns/1ns
`include "kiwi_params.svh"

module kiwi_shared_ram #(
    parameter int aw = `KIWI_RAM_AW
) (
    input  logic          clk,
    input  logic [aw-1:0] addr0,
    input  logic [7:0]    data0,
    input  logic          we0,
    output logic [7:0]    q0,
    input  logic [aw-1:0] addr1,
    input  logic [7:0]    data1,
    input  logic          we1,
    output logic [7:0]    q1
);

    logic [7:0] mem [2**aw];

    // Port 0 main CPU, port 1 sound CPU
    always_ff @(posedge clk) begin
        if (we0) begin
            mem[addr0] <= data0;
        end
        // Same address on both ports, sound CPU write lands
        if (we1) begin
            mem[addr1] <= data1;
        end
        // Old data on a same-cycle write
        q0 <= mem[addr0];
        q1 <= mem[addr1];
    end

endmodule

// ==== rtl/kiwi_main.sv ====
`timescale 1ns/1ns
`include "kiwi_params.svh"

module kiwi_main (
    input  logic                    clk,
    input  logic                    rst,
    // CPU request
    input  kiwi_pkg::cpu_req_t      req,
    input  logic                    req_valid,
    output logic                    req_ready,
    // CPU response
    output kiwi_pkg::cpu_rsp_t      rsp,
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    // Video devices
    output logic                    vram_cs,
    output logic                    vctrl_cs,
    output logic                    pal_cs,
    input  logic [7:0]              vram_dout,
    input  logic [7:0]              pal_dout,
    // Shared address and data bus
    output logic [12:0]             cpu_addr,
    output logic [7:0]              cpu_dout,
    output logic                    cpu_rnw,
    // ROM
    output logic [`KIWI_ROM_AW-1:0] rom_addr,
    output logic                    rom_cs,
    input  logic                    rom_ok,
    input  logic [7:0]              rom_data,
    // Sound CPU
    output logic                    snd_rstn,
    input  logic [`KIWI_RAM_AW-1:0] shr_addr,
    input  logic [7:0]              shr_din,
    input  logic                    shr_we,
    output logic [7:0]              shr_dout,
    // Interrupt
    input  logic                    lvbl,
    output logic                    irq,
    input  logic                    irq_ack
);

    kiwi_pkg::cpu_req_t      cur;
    kiwi_pkg::dev_sel_t      sel;
    logic [`KIWI_ROM_AW-1:0] dec_rom_addr;
    logic [2:0]              bank;
    logic                    ram_we;
    logic                    bank_we;
    logic [7:0]              ram_dout;

    // Devices see the held request
    assign cpu_addr = cur.addr[12:0];
    assign cpu_dout = cur.data;
    assign cpu_rnw  = ~cur.we;

    kiwi_addr_decode u_decode (
        .addr     (cur.addr),
        .bank     (bank),
        .sel      (sel),
        .rom_addr (dec_rom_addr)
    );

    kiwi_bus_ctrl u_bus (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .rsp         (rsp),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .sel         (sel),
        .rom_addr_in (dec_rom_addr),
        .rom_cs      (rom_cs),
        .vram_cs     (vram_cs),
        .vctrl_cs    (vctrl_cs),
        .pal_cs      (pal_cs),
        .ram_we      (ram_we),
        .bank_we     (bank_we),
        .rom_addr    (rom_addr),
        .rom_ok      (rom_ok),
        .rom_data    (rom_data),
        .ram_dout    (ram_dout),
        .vram_dout   (vram_dout),
        .pal_dout    (pal_dout),
        .cur         (cur)
    );

    kiwi_sysctl u_sysctl (
        .clk      (clk),
        .rst      (rst),
        .bank_we  (bank_we),
        .wdata    (cur.data),
        .lvbl     (lvbl),
        .irq_ack  (irq_ack),
        .bank     (bank),
        .snd_rstn (snd_rstn),
        .irq      (irq)
    );

    // No arbitration, both CPUs reach the array every cycle
    kiwi_shared_ram #(
        .aw (`KIWI_RAM_AW)
    ) u_shr (
        .clk   (clk),
        .addr0 (cur.addr[`KIWI_RAM_AW-1:0]),
        .data0 (cur.data),
        .we0   (ram_we),
        .q0    (ram_dout),
        .addr1 (shr_addr),
        .data1 (shr_din),
        .we1   (shr_we),
        .q1    (shr_dout)
    );

endmodule

// ==== test/kiwi_properties.sv ====
`timescale 1ns/1ns

module kiwi_properties (
    input logic       clk,
    input logic       rst,
    input logic       rom_cs,
    input logic       vram_cs,
    input logic       vctrl_cs,
    input logic       pal_cs,
    input logic       req_ready,
    input logic       rsp_valid,
    input logic       rsp_ready,
    input logic [7:0] rsp_data
);

    // Assertion failures so far
    int fails = 0;

    // One device at most, and none left up once the response is out
    a_one_sel: assert property (@(posedge clk) disable iff (rst)
        $onehot0({rom_cs, vram_cs, vctrl_cs, pal_cs, rsp_valid}))
        else begin
            $error("device select high together with another select or the response");
            fails++;
        end

    // Stalled response keeps its byte
    a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
        else begin
            $error("response changed or dropped while stalled");
            fails++;
        end

    // Single access in flight
    a_no_accept: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |-> !req_ready)
        else begin
            $error("request ready while a response is pending");
            fails++;
        end

endmodule

bind kiwi_bus_ctrl kiwi_properties u_props (
    .clk       (clk),
    .rst       (rst),
    .rom_cs    (rom_cs),
    .vram_cs   (vram_cs),
    .vctrl_cs  (vctrl_cs),
    .pal_cs    (pal_cs),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_data  (rsp.data)
);

// ==== test/kiwi_checker.sv ====
`timescale 1ns/1ns
`include "kiwi_params.svh"

module kiwi_checker (
    input  logic               clk,
    input  logic               rst,
    input  kiwi_pkg::cpu_req_t req,
    input  logic               req_valid,
    input  logic               req_ready,
    input  kiwi_pkg::cpu_rsp_t rsp,
    input  logic               rsp_valid,
    input  logic               rsp_ready,
    input  logic               rom_cs,
    input  logic               vram_cs,
    input  logic               vctrl_cs,
    input  logic               pal_cs,
    input  logic [12:0]        cpu_addr,
    input  logic [7:0]         cpu_dout,
    input  logic               cpu_rnw,
    input  logic [16:0]        rom_addr,
    input  logic               snd_rstn,
    input  logic [12:0]        shr_addr,
    input  logic [7:0]         shr_din,
    input  logic               shr_we,
    input  logic [7:0]         shr_dout,
    input  logic               lvbl,
    input  logic               irq,
    input  logic               irq_ack,
    output int                 errors,
    output int                 checks,
    output int                 rsp_count
);

    kiwi_pkg::cpu_req_t cur;
    int                 acc_cyc;
    int                 cyc;
    logic               busy;
    logic               rsp_l;
    // Model of bank latch, sound reset and RAM contents
    logic [2:0]         bank_m;
    logic               snd_m;
    logic [7:0]         ram_m [int];
    // Expected sound port byte for the next cycle
    logic [7:0]         exp_q1;
    logic               q1_known;
    logic               irq_m;
    logic               lvbl_m;

    initial begin
        errors    = 0;
        checks    = 0;
        rsp_count = 0;
    end

    // Upper window lands on 8 KB pages counted from the bank base
    function automatic logic [16:0] ref_rom_addr(input logic [15:0] a, input logic [2:0] b);
        int page;
        if (!a[15]) begin
            return {1'b0, a};
        end
        page = `KIWI_BANK_BASE + b;
        return 17'(page * 8192 + int'(a[12:0]));
    endfunction

    // Select pattern {rom, vram, vctrl, pal}
    function automatic logic [3:0] ref_cs(input logic [15:0] a);
        if (a < 16'hc000) return 4'b1000;
        if (a < 16'he000) return 4'b0100;
        if (a < 16'hf000) return 4'b0000;
        if (a < 16'hf400) return 4'b0010;
        if (a >= 16'hf800 && a < 16'hfc00) return 4'b0001;
        return 4'b0000;
    endfunction

    // Expected response byte
    function automatic logic [7:0] ref_read(input kiwi_pkg::cpu_req_t r, input logic [2:0] b);
        logic [16:0] ra;
        logic [3:0]  cs;
        ra = ref_rom_addr(r.addr, b);
        cs = ref_cs(r.addr);
        if (r.we) return 8'h00;
        if (r.addr < 16'hc000) return ra[7:0] ^ ra[16:9];
        if (r.addr[15:12] == 4'he) return ram_m[int'(r.addr[12:0])];
        if (cs[2] || cs[1]) return r.addr[7:0] + 8'h11;
        if (cs[0]) return ~r.addr[7:0];
        return `KIWI_UNMAPPED;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error %s expected %h actual %h", name, exp, act);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            busy     = 1'b0;
            rsp_l    = 1'b0;
            cyc      = 0;
            bank_m   = 3'd0;
            snd_m    = 1'b0;
            q1_known = 1'b0;
            irq_m    = 1'b0;
            lvbl_m   = 1'b0;
        end else begin
            cyc++;
            // Interrupt one cycle after the lvbl fall
            check("irq", irq_m, irq);
            if (lvbl_m && !lvbl) begin
                irq_m = 1'b1;
            end else if (irq_ack) begin
                irq_m = 1'b0;
            end
            lvbl_m = lvbl;
            // Sound port reads old data
            if (q1_known) begin
                check("snd_read", exp_q1, shr_dout);
            end
            q1_known = ram_m.exists(int'(shr_addr));
            if (q1_known) begin
                exp_q1 = ram_m[int'(shr_addr)];
            end
            if (busy && cyc == acc_cyc + 2) begin
                check("select", ref_cs(cur.addr), {rom_cs, vram_cs, vctrl_cs, pal_cs});
                check("bus_out", {cur.addr[12:0], cur.data, !cur.we},
                      {cpu_addr, cpu_dout, cpu_rnw});
                if (rom_cs) begin
                    check("rom_addr", ref_rom_addr(cur.addr, bank_m), rom_addr);
                end
                // Main write lands on this edge
                if (cur.we && cur.addr[15:12] == 4'he) begin
                    ram_m[int'(cur.addr[12:0])] = cur.data;
                end
            end
            // Port 1 wins a collision
            if (shr_we) begin
                ram_m[int'(shr_addr)] = shr_din;
            end
            if (rsp_valid && !rsp_l) begin
                check("select_drop", 4'b0000, {rom_cs, vram_cs, vctrl_cs, pal_cs});
                if (busy && ref_cs(cur.addr) != 4'b1000) begin
                    check("latency", 3, cyc - acc_cyc - 1);
                end
            end
            rsp_l = rsp_valid;
            if (rsp_valid && rsp_ready) begin
                rsp_count++;
                if (!busy) begin
                    errors++;
                    $display("Response seen without a pending request");
                end else begin
                    check("read_data", ref_read(cur, bank_m), rsp.data);
                    if (cur.we && cur.addr[15:8] == 8'hf6) begin
                        bank_m = cur.data[2:0];
                        snd_m  = cur.data[4];
                        check("snd_rstn", snd_m, snd_rstn);
                    end
                    busy = 1'b0;
                end
            end
            if (req_valid && req_ready) begin
                if (busy) begin
                    errors++;
                    $display("Request accepted while another was in flight");
                end
                cur     = req;
                acc_cyc = cyc;
                busy    = 1'b1;
            end
        end
    end

endmodule

// ==== test/kiwi_tb.sv ====
`timescale 1ns/1ns
`include "kiwi_params.svh"

module kiwi_tb;

    localparam int n_tx      = 70;
    localparam int max_delay = 5;
    // Reset plus per access overhead with ROM wait and stalls plus the IRQ phase
    localparam int limit     = 10 + n_tx * (10 + max_delay + 8) + 200;

    logic               clk = 1'b0;
    logic               rst;
    kiwi_pkg::cpu_req_t req;
    logic               req_valid;
    logic               req_ready;
    kiwi_pkg::cpu_rsp_t rsp;
    logic               rsp_valid;
    logic               rsp_ready = 1'b0;
    logic               vram_cs;
    logic               vctrl_cs;
    logic               pal_cs;
    logic [7:0]         vram_dout;
    logic [7:0]         pal_dout;
    logic [12:0]        cpu_addr;
    logic [7:0]         cpu_dout;
    logic               cpu_rnw;
    logic [16:0]        rom_addr;
    logic               rom_cs;
    logic               rom_ok = 1'b0;
    logic [7:0]         rom_data;
    logic               snd_rstn;
    logic [12:0]        shr_addr;
    logic [7:0]         shr_din;
    logic               shr_we;
    logic [7:0]         shr_dout;
    logic               lvbl;
    logic               irq;
    logic               irq_ack;
    logic [31:0]        rnd = 32'he12e_74ad;
    logic [31:0]        bg = 32'he12e_74ad;
    int                 rom_wait = 0;
    int                 cycles = 0;
    int                 sent = 0;
    int                 errors;
    int                 checks;
    int                 rsp_count;

    always #50 clk = ~clk;

    // Device models
    assign rom_data  = rom_addr[7:0] ^ rom_addr[16:9];
    assign vram_dout = cpu_addr[7:0] + 8'h11;
    assign pal_dout  = ~cpu_addr[7:0];

    kiwi_main dut (.*);

    kiwi_checker u_chk (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // ROM wait states and response back-pressure
    always @(posedge clk) begin
        #5;
        bg = xorshift(bg);
        rsp_ready = (bg[1:0] != 2'b00);
        if (!rom_cs) begin
            rom_ok   = 1'b0;
            rom_wait = int'(bg[10:8]) % (max_delay + 1);
        end else if (rom_wait == 0) begin
            rom_ok = 1'b1;
        end else begin
            rom_wait--;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic access(input logic [15:0] addr, input logic [7:0] data, input logic we);
        @(posedge clk);
        #5;
        req       = '{addr: addr, data: data, we: we};
        req_valid = 1'b1;
        do @(posedge clk); while (!req_ready);
        #5;
        req_valid = 1'b0;
        do @(posedge clk); while (!(rsp_valid && rsp_ready));
        sent++;
    endtask

    task automatic snd_write(input logic [12:0] a, input logic [7:0] d);
        @(posedge clk);
        #5;
        shr_addr = a;
        shr_din  = d;
        shr_we   = 1'b1;
        @(posedge clk);
        #5;
        shr_we = 1'b0;
    endtask

    // Checker compares shr_dout each cycle
    task automatic snd_read(input logic [12:0] a);
        @(posedge clk);
        #5;
        shr_addr = a;
        repeat (2) @(posedge clk);
    endtask

    initial begin
        rst       = 1'b1;
        req       = '0;
        req_valid = 1'b0;
        shr_addr  = '0;
        shr_din   = '0;
        shr_we    = 1'b0;
        lvbl      = 1'b1;
        irq_ack   = 1'b0;
        repeat (10) @(posedge clk);
        #5;
        rst = 1'b0;
        // Fixed ROM area
        for (int i = 0; i < 8; i++) begin
            rnd = xorshift(rnd);
            access({1'b0, rnd[14:0]}, 8'h00, 1'b0);
        end
        // Bank latch then banked window
        for (int i = 0; i < 3; i++) begin
            rnd = xorshift(rnd);
            access(16'hf600, rnd[7:0], 1'b1);
            for (int j = 0; j < 4; j++) begin
                rnd = xorshift(rnd);
                access({2'b10, rnd[13:0]}, 8'h00, 1'b0);
            end
        end
        // Shared RAM from both sides
        for (int i = 0; i < 4; i++) begin
            rnd = xorshift(rnd);
            access({4'he, rnd[11:0]}, rnd[23:16], 1'b1);
            access({4'he, rnd[11:0]}, 8'h00, 1'b0);
            snd_read({1'b0, rnd[11:0]});
            rnd = xorshift(rnd);
            snd_write({1'b0, rnd[11:0]}, rnd[23:16]);
            access({4'he, rnd[11:0]}, 8'h00, 1'b0);
        end
        // Video devices and open bus
        rnd = xorshift(rnd);
        access({3'b110, rnd[12:0]}, 8'h00, 1'b0);
        access({6'b111100, rnd[9:0]}, 8'h00, 1'b0);
        access({6'b111110, rnd[9:0]}, 8'h00, 1'b0);
        access(16'hf400, 8'h00, 1'b0);
        access(16'hfc00, 8'h00, 1'b0);
        access(16'hf6aa, 8'h00, 1'b0);
        // Vertical blank interrupt
        repeat (3) @(posedge clk);
        #5;
        lvbl = 1'b0;
        repeat (3) @(posedge clk);
        #5;
        irq_ack = 1'b1;
        @(posedge clk);
        #5;
        irq_ack = 1'b0;
        lvbl    = 1'b1;
        // Mixed traffic, RAM only written so reads stay known
        for (int i = 0; i < 20; i++) begin
            rnd = xorshift(rnd);
            access(rnd[31:16], rnd[7:0], rnd[8] || rnd[31:28] == 4'he);
        end
        repeat (4) @(posedge clk);
        $display("checks %0d errors %0d assertion failures %0d responses %0d sent %0d",
                 checks, errors, dut.u_bus.u_props.fails, rsp_count, sent);
        if (errors == 0 && dut.u_bus.u_props.fails == 0 && rsp_count == sent) begin
            $display("TEST RESULT: PASS");
        end else begin
            if (rsp_count != sent) begin
                $display("Number of responses does not match number of requests");
            end
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+rtl
rtl/kiwi_pkg.sv
rtl/kiwi_addr_decode.sv
rtl/kiwi_bus_ctrl.sv
rtl/kiwi_sysctl.sv
rtl/kiwi_shared_ram.sv
rtl/kiwi_main.sv
test/kiwi_properties.sv
test/kiwi_checker.sv
test/kiwi_tb.sv

// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wall -f files.f --top-module kiwi_tb -o kiwi_sim

run: compile
	obj_dir/kiwi_sim > sim.log 2>&1; cat sim.log
	@! grep -q "TEST RESULT: FAIL" sim.log && grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
